// ==== compile.f ====
verilog/cpu_pkg.sv
verilog/io_out_reg.sv
verilog/fetch_stage.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/hazard_unit.sv
verilog/execute_stage.sv
verilog/mem_stage.sv
verilog/cpu_top.sv
verif/cpu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f compile.f \
  -o cpu_tb_sim || exit 1
sim_out=$(./obj_dir/cpu_tb_sim)
echo "$sim_out"
echo "$sim_out" | grep -q "Simulation PASSED" && exit 0 || exit 1

// ==== verif/cpu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_tb;
  import cpu_pkg::*;

  localparam int          CLK_PERIOD     = 4;
  localparam int          RESET_CYCLES   = 3;
  localparam int          RUN_CYCLES     = 300;
  localparam int          ALU_CASES      = 18;
  localparam int          NUM_RUNS       = ALU_CASES + 4;  // one program per run
  localparam int          CYCLES_PER_RUN = 400;
  localparam logic [31:0] SEED           = 32'h2115_112b;

  logic       clk;
  logic       reset;
  logic       prog_we;
  imem_addr_t prog_addr;
  inst_t      prog_data;
  led_t       ledr;
  hex_t       hex;

  inst_t prog [$];  // program under construction
  int    led_errors;
  int    hex_errors;

  cpu_top cpu_top_i (
    .clk       (clk),
    .reset     (reset),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .ledr      (ledr),
    .hex       (hex)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // watchdog sized from the number of program runs
  initial begin
    #(NUM_RUNS * CYCLES_PER_RUN * CLK_PERIOD);
    $display("timeout: the tests did not finish within %0d cycles",
             NUM_RUNS * CYCLES_PER_RUN);
    $display("Simulation FAILED");
    $finish;
  end

  // ------------------------------------------------------------------------
  // instruction encoders and reference model
  // ------------------------------------------------------------------------
  function automatic inst_t alur_inst(op2_t op2, reg_no_t rd, reg_no_t rs, reg_no_t rt);
    return {OP1_ALUR, op2, 6'b000000, rd, rs, rt};
  endfunction

  // immediate ALU, load, store, branch and jal share this layout
  function automatic inst_t imm_inst(op1_t op1, reg_no_t rs, reg_no_t rt, logic [15:0] imm);
    return {op1, 2'b00, imm, rs, rt};
  endfunction

  function automatic word_t sign_extend(logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  function automatic word_t alu_model(op1_t op1, op2_t op2, word_t a, word_t b);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    sa = a;
    sb = b;
    case (op1)
      OP1_ADDI: return a + b;
      OP1_ANDI: return a & b;
      OP1_ORI:  return a | b;
      OP1_XORI: return a ^ b;
      default:  ;
    endcase
    case (op2)
      OP2_EQ:   return {31'd0, sa == sb};
      OP2_LT:   return {31'd0, sa < sb};
      OP2_LE:   return {31'd0, sa <= sb};
      OP2_NE:   return {31'd0, sa != sb};
      OP2_ADD:  return a + b;
      OP2_AND:  return a & b;
      OP2_OR:   return a | b;
      OP2_XOR:  return a ^ b;
      OP2_SUB:  return a - b;
      OP2_NAND: return ~(a & b);
      OP2_NOR:  return ~(a | b);
      OP2_NXOR: return ~(a ^ b);
      OP2_RSHF: return sa >>> b[4:0];  // sign fill
      OP2_LSHF: return a << b[4:0];
      default:  return '0;
    endcase
  endfunction

  // ------------------------------------------------------------------------
  // program handling and compare tasks
  // ------------------------------------------------------------------------
  task automatic finish_program();
    prog.push_back(imm_inst(OP1_BEQ, 4'd0, 4'd0, 16'hFFFF));  // branch to itself
    prog.push_back('0);  // nops on the wrong path past the halt
    prog.push_back('0);
  endtask

  // program goes in while reset is high, then reset is held 3 more cycles
  task automatic load_program();
    @(posedge clk);
    #1;
    reset = 1'b1;
    for (int i = 0; i < prog.size(); i++) begin
      prog_we   = 1'b1;
      prog_addr = imem_addr_t'(START_PC >> 2) + imem_addr_t'(i);
      prog_data = prog[i];
      @(posedge clk);
      #1;
    end
    prog_we = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
  endtask

  task automatic wait_run();
    repeat (RUN_CYCLES) @(posedge clk);
    #1;
  endtask

  task automatic check_led(string test, led_t expected, led_t actual);
    if (actual !== expected) begin
      led_errors++;
      $display("error in %s: ledr expected %h, actual %h", test, expected, actual);
    end
  endtask

  task automatic check_hex(string test, hex_t expected, hex_t actual);
    if (actual !== expected) begin
      hex_errors++;
      $display("error in %s: hex expected %h, actual %h", test, expected, actual);
    end
  endtask

  // ------------------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------------------
  task automatic check_reset_quiet();
    prog.delete();
    prog.push_back(imm_inst(OP1_ADDI, 4'd0, 4'd1, 16'h1234));
    prog.push_back(imm_inst(OP1_ADDI, 4'd1, 4'd2, 16'h00FF));
    prog.push_back(alur_inst(OP2_XOR, 4'd3, 4'd1, 4'd2));
    prog.push_back(alur_inst(OP2_SUB, 4'd4, 4'd3, 4'd1));
    finish_program();
    load_program();
    check_led("reset", '0, ledr);
    check_hex("reset", '0, hex);
    wait_run();
    check_led("no stores", '0, ledr);
    check_hex("no stores", '0, hex);
  endtask

  task automatic alu_case(op1_t op1, op2_t op2);
    logic [15:0] a16;
    logic [15:0] b16;
    logic [4:0]  shamt;
    word_t       b;
    word_t       expected;
    string       name;
    a16   = 16'($urandom);
    b16   = 16'($urandom);
    shamt = 5'($urandom);
    if (op1 == OP1_ALUR && (op2 == OP2_EQ || op2 == OP2_LE)) begin
      b16 = a16;  // equal operands, true side of the compare
    end
    b = sign_extend(b16);
    prog.delete();
    prog.push_back(imm_inst(OP1_ADDI, 4'd0, 4'd1, a16));
    prog.push_back(imm_inst(OP1_ADDI, 4'd0, 4'd2, b16));
    prog.push_back(imm_inst(OP1_ADDI, 4'd0, 4'd3, {11'd0, shamt}));
    if (op1 != OP1_ALUR) begin
      prog.push_back(imm_inst(op1, 4'd1, 4'd4, b16));
      name = $sformatf("alu %s", op1.name());
    end else if (op2 == OP2_RSHF || op2 == OP2_LSHF) begin
      prog.push_back(alur_inst(op2, 4'd4, 4'd1, 4'd3));
      b    = {27'd0, shamt};
      name = $sformatf("alu %s", op2.name());
    end else begin
      prog.push_back(alur_inst(op2, 4'd4, 4'd1, 4'd2));
      name = $sformatf("alu %s", op2.name());
    end
    prog.push_back(imm_inst(OP1_SW, 4'd0, 4'd4, ADDR_HEX[15:0]));
    finish_program();
    load_program();
    wait_run();
    expected = alu_model(op1, op2, sign_extend(a16), b);
    check_hex(name, hex_t'(expected), hex);
  endtask

  task automatic exercise_alu_ops();
    op2_t alur_ops [14] = '{OP2_EQ, OP2_LT, OP2_LE, OP2_NE, OP2_ADD, OP2_AND, OP2_OR,
                            OP2_XOR, OP2_SUB, OP2_NAND, OP2_NOR, OP2_NXOR, OP2_RSHF,
                            OP2_LSHF};
    op1_t imm_ops [4] = '{OP1_ADDI, OP1_ANDI, OP1_ORI, OP1_XORI};
    foreach (alur_ops[i]) begin
      alu_case(OP1_ALUR, alur_ops[i]);
    end
    foreach (imm_ops[i]) begin
      alu_case(imm_ops[i], OP2_ADD);
    end
  endtask

  task automatic chain_forwarding();
    logic [15:0] c1;
    logic [15:0] c2;
    word_t       sum;
    c1 = 16'($urandom);
    c2 = 16'($urandom);
    prog.delete();
    prog.push_back(imm_inst(OP1_ADDI, 4'd0, 4'd1, c1));
    prog.push_back(imm_inst(OP1_ADDI, 4'd1, 4'd2, c2));    // r1 from execute
    prog.push_back(alur_inst(OP2_ADD, 4'd3, 4'd2, 4'd1));  // r1 from memory
    prog.push_back(alur_inst(OP2_ADD, 4'd4, 4'd3, 4'd1));  // r1 from writeback
    prog.push_back(alur_inst(OP2_ADD, 4'd5, 4'd4, 4'd2));
    prog.push_back(imm_inst(OP1_SW, 4'd0, 4'd5, ADDR_HEX[15:0]));
    finish_program();
    load_program();
    wait_run();
    // r5 = 4*c1 + 2*c2
    sum = (sign_extend(c1) << 2) + (sign_extend(c2) << 1);
    check_hex("forwarding", hex_t'(sum), hex);
  endtask

  task automatic load_use_stall();
    logic [15:0] v;
    logic [15:0] k;
    word_t       sum;
    v = 16'($urandom);
    k = 16'($urandom);
    prog.delete();
    prog.push_back(imm_inst(OP1_ADDI, 4'd0, 4'd1, v));
    prog.push_back(imm_inst(OP1_ADDI, 4'd0, 4'd2, 16'h0040));  // data base address
    prog.push_back(imm_inst(OP1_SW, 4'd2, 4'd1, 16'd8));
    prog.push_back(imm_inst(OP1_LW, 4'd2, 4'd3, 16'd8));
    prog.push_back(imm_inst(OP1_ADDI, 4'd3, 4'd4, k));         // uses the load at once
    prog.push_back(imm_inst(OP1_SW, 4'd0, 4'd4, ADDR_HEX[15:0]));
    prog.push_back(imm_inst(OP1_LW, 4'd2, 4'd5, 16'd8));
    prog.push_back(imm_inst(OP1_SW, 4'd0, 4'd5, ADDR_LEDR[15:0]));  // store data stall
    finish_program();
    load_program();
    wait_run();
    sum = sign_extend(v) + sign_extend(k);
    check_hex("load use", hex_t'(sum), hex);
    check_led("load use", led_t'(sign_extend(v)), ledr);
  endtask

  // markers add 1 to r7 and must never execute
  task automatic branch_path(op1_t op1, reg_no_t rs, reg_no_t rt, logic taken,
                             logic [15:0] bit_val);
    if (taken) begin
      prog.push_back(imm_inst(op1, rs, rt, 16'd2));
      prog.push_back(imm_inst(OP1_ADDI, 4'd7, 4'd7, 16'd1));
      prog.push_back(imm_inst(OP1_ADDI, 4'd7, 4'd7, 16'd1));
    end else begin
      prog.push_back(imm_inst(op1, rs, rt, 16'd1));  // taken would skip the add
    end
    prog.push_back(imm_inst(OP1_ADDI, 4'd7, 4'd7, bit_val));
  endtask

  task automatic branch_paths();
    logic [15:0] rnd;
    logic [15:0] a16;
    logic [15:0] d16;
    int          jal_idx;
    word_t       link;
    rnd = 16'($urandom);
    a16 = {rnd[15], rnd[15:1]};  // half range so a + d stays in range
    d16 = {8'd0, 8'($urandom) | 8'd1};
    prog.delete();
    prog.push_back(imm_inst(OP1_ADDI, 4'd0, 4'd1, a16));   // r1 = a
    prog.push_back(imm_inst(OP1_ADDI, 4'd1, 4'd2, d16));   // r2 = a + d
    prog.push_back(imm_inst(OP1_ADDI, 4'd1, 4'd3, 16'd0));  // r3 = a
    prog.push_back(imm_inst(OP1_ADDI, 4'd0, 4'd7, 16'd0));
    branch_path(OP1_BEQ, 4'd1, 4'd3, 1'b1, 16'h0002);
    branch_path(OP1_BEQ, 4'd1, 4'd2, 1'b0, 16'h0004);
    branch_path(OP1_BLT, 4'd1, 4'd2, 1'b1, 16'h0008);
    branch_path(OP1_BLT, 4'd2, 4'd1, 1'b0, 16'h0010);
    branch_path(OP1_BLE, 4'd1, 4'd3, 1'b1, 16'h0020);
    branch_path(OP1_BLE, 4'd2, 4'd1, 1'b0, 16'h0040);
    branch_path(OP1_BNE, 4'd1, 4'd2, 1'b1, 16'h0080);
    branch_path(OP1_BNE, 4'd1, 4'd3, 1'b0, 16'h0100);
    // jal through r0, so the target is absolute: three slots past the jal
    jal_idx = prog.size();
    link    = START_PC + word_t'(4 * jal_idx) + INST_SIZE;
    prog.push_back(imm_inst(OP1_JAL, 4'd0, 4'd6, 16'((link + 32'd8) >> 2)));
    prog.push_back(imm_inst(OP1_ADDI, 4'd7, 4'd7, 16'd1));
    prog.push_back(imm_inst(OP1_ADDI, 4'd7, 4'd7, 16'd1));
    prog.push_back(imm_inst(OP1_ADDI, 4'd7, 4'd7, 16'h0200));
    prog.push_back(imm_inst(OP1_SW, 4'd0, 4'd7, ADDR_LEDR[15:0]));
    prog.push_back(imm_inst(OP1_SW, 4'd0, 4'd6, ADDR_HEX[15:0]));
    finish_program();
    load_program();
    wait_run();
    check_led("branches", 10'h3FE, ledr);  // bits 1 to 9, no marker
    check_hex("jal link", hex_t'(link), hex);
  endtask

  // ------------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------------
  initial begin
    reset      = 1'b1;
    prog_we    = 1'b0;
    prog_addr  = '0;
    prog_data  = '0;
    led_errors = 0;
    hex_errors = 0;
    void'($urandom(SEED));

    check_reset_quiet();
    exercise_alu_ops();
    chain_forwarding();
    load_use_stall();
    branch_paths();

    $display("checks failed: ledr %0d, hex %0d", led_errors, hex_errors);
    if (led_errors + hex_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

  // ------------------------------------------------------------------------
  // widths and basic types
  // ------------------------------------------------------------------------
  localparam int DBITS = 32;

  typedef logic [DBITS-1:0] word_t;
  typedef logic [31:0]      inst_t;
  typedef logic [3:0]       reg_no_t;

  localparam word_t INST_SIZE = 32'd4;  // pc step
  localparam word_t START_PC  = 32'h0000_0100;

  // memories kept small for simulation
  localparam int IMEM_WORDS = 1024;
  localparam int DMEM_WORDS = 1024;

  typedef logic [$clog2(IMEM_WORDS)-1:0] imem_addr_t;  // word index

  // memory-mapped outputs
  localparam word_t ADDR_HEX  = 32'hFFFF_F000;
  localparam word_t ADDR_LEDR = 32'hFFFF_F020;

  typedef logic [9:0]  led_t;
  typedef logic [23:0] hex_t;

  // ------------------------------------------------------------------------
  // opcodes
  // ------------------------------------------------------------------------
  typedef enum logic [5:0] {
    OP1_ALUR = 6'b000000,
    OP1_BEQ  = 6'b001000,
    OP1_BLT  = 6'b001001,
    OP1_BLE  = 6'b001010,
    OP1_BNE  = 6'b001011,
    OP1_JAL  = 6'b001100,
    OP1_LW   = 6'b010010,
    OP1_SW   = 6'b011010,
    OP1_ADDI = 6'b100000,
    OP1_ANDI = 6'b100100,
    OP1_ORI  = 6'b100101,
    OP1_XORI = 6'b100110
  } op1_t;

  // secondary codes, used only under OP1_ALUR
  typedef enum logic [7:0] {
    OP2_EQ   = 8'b00001000,
    OP2_LT   = 8'b00001001,
    OP2_LE   = 8'b00001010,
    OP2_NE   = 8'b00001011,
    OP2_ADD  = 8'b00100000,
    OP2_AND  = 8'b00100100,
    OP2_OR   = 8'b00100101,
    OP2_XOR  = 8'b00100110,
    OP2_SUB  = 8'b00101000,
    OP2_NAND = 8'b00101100,
    OP2_NOR  = 8'b00101101,
    OP2_NXOR = 8'b00101110,
    OP2_RSHF = 8'b00110000,
    OP2_LSHF = 8'b00110001
  } op2_t;

  // operand source picked in decode
  typedef enum logic [1:0] {
    FWD_REGFILE  = 2'd0,
    FWD_FROM_EX  = 2'd1,
    FWD_FROM_MEM = 2'd2,
    FWD_FROM_WB  = 2'd3
  } fwd_sel_t;

endpackage

`default_nettype wire

// ==== verilog/cpu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_top (
  input  logic                clk,
  input  logic                reset,
  input  logic                prog_we,
  input  cpu_pkg::imem_addr_t prog_addr,
  input  cpu_pkg::inst_t      prog_data,
  output cpu_pkg::led_t       ledr,
  output cpu_pkg::hex_t       hex
);
  import cpu_pkg::*;

  // fetch -> decode
  inst_t    fe_inst;
  word_t    fe_pc_plus;
  // decode <-> reg_file, hazard_unit
  reg_no_t  id_rs, id_rt;
  word_t    rf_rs_val, rf_rt_val;
  fwd_sel_t fwd_sel_rs, fwd_sel_rt;
  logic     stall;
  // decode -> execute
  op1_t     id_op1;
  op2_t     id_op2;
  word_t    id_a_val, id_b_val, id_imm_val, id_pc;
  reg_no_t  id_wregno;
  logic     id_is_br, id_is_jmp, id_rd_mem, id_wr_mem, id_wr_reg;
  // execute -> memory, fetch
  word_t    ex_val, ex_target, ex_alu_out, ex_store_val;
  logic     ex_redirect, ex_rd_mem, ex_wr_mem, ex_wr_reg;
  reg_no_t  ex_wregno;
  // memory -> writeback
  word_t    mem_val, wb_val;
  reg_no_t  wb_regno;
  logic     wb_we;

  // ------------------------------------------------------------------------
  // pipeline stages
  // ------------------------------------------------------------------------
  fetch_stage fetch_stage_i (
    .clk       (clk),
    .reset     (reset),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .stall     (stall),
    .redirect  (ex_redirect),
    .target    (ex_target),
    .inst      (fe_inst),
    .pc_plus   (fe_pc_plus)
  );

  decode_stage decode_stage_i (
    .clk        (clk),
    .reset      (reset),
    .inst       (fe_inst),
    .pc_plus    (fe_pc_plus),
    .stall      (stall),
    .redirect   (ex_redirect),
    .rs         (id_rs),
    .rt         (id_rt),
    .rs_val     (rf_rs_val),
    .rt_val     (rf_rt_val),
    .fwd_sel_rs (fwd_sel_rs),
    .fwd_sel_rt (fwd_sel_rt),
    .ex_val     (ex_val),
    .mem_val    (mem_val),
    .wb_val     (wb_val),
    .op1        (id_op1),
    .op2        (id_op2),
    .a_val      (id_a_val),
    .b_val      (id_b_val),
    .imm_val    (id_imm_val),
    .pc_out     (id_pc),
    .wregno     (id_wregno),
    .is_br      (id_is_br),
    .is_jmp     (id_is_jmp),
    .rd_mem     (id_rd_mem),
    .wr_mem     (id_wr_mem),
    .wr_reg     (id_wr_reg)
  );

  execute_stage execute_stage_i (
    .clk        (clk),
    .reset      (reset),
    .op1        (id_op1),
    .op2        (id_op2),
    .a_val      (id_a_val),
    .b_val      (id_b_val),
    .imm_val    (id_imm_val),
    .pc_in      (id_pc),
    .wregno     (id_wregno),
    .is_br      (id_is_br),
    .is_jmp     (id_is_jmp),
    .rd_mem     (id_rd_mem),
    .wr_mem     (id_wr_mem),
    .wr_reg     (id_wr_reg),
    .ex_val     (ex_val),
    .redirect   (ex_redirect),
    .target     (ex_target),
    .alu_out    (ex_alu_out),
    .store_val  (ex_store_val),
    .wregno_out (ex_wregno),
    .rd_mem_out (ex_rd_mem),
    .wr_mem_out (ex_wr_mem),
    .wr_reg_out (ex_wr_reg)
  );

  mem_stage mem_stage_i (
    .clk       (clk),
    .reset     (reset),
    .alu_out   (ex_alu_out),
    .store_val (ex_store_val),
    .wregno    (ex_wregno),
    .rd_mem    (ex_rd_mem),
    .wr_mem    (ex_wr_mem),
    .wr_reg    (ex_wr_reg),
    .mem_val   (mem_val),
    .wb_val    (wb_val),
    .wb_regno  (wb_regno),
    .wb_we     (wb_we),
    .ledr      (ledr),
    .hex       (hex)
  );

  // ------------------------------------------------------------------------
  // registers and hazards
  // ------------------------------------------------------------------------
  reg_file reg_file_i (
    .clk      (clk),
    .reset    (reset),
    .rs       (id_rs),
    .rt       (id_rt),
    .rs_val   (rf_rs_val),
    .rt_val   (rf_rt_val),
    .wb_we    (wb_we),
    .wb_regno (wb_regno),
    .wb_val   (wb_val)
  );

  hazard_unit hazard_unit_i (
    .rs         (id_rs),
    .rt         (id_rt),
    .ex_wregno  (id_wregno),  // producer sitting in execute
    .mem_wregno (ex_wregno),
    .wb_regno   (wb_regno),
    .ex_wr_reg  (id_wr_reg),
    .ex_rd_mem  (id_rd_mem),
    .mem_wr_reg (ex_wr_reg),
    .wb_we      (wb_we),
    .fwd_sel_rs (fwd_sel_rs),
    .fwd_sel_rt (fwd_sel_rt),
    .stall      (stall)
  );

endmodule

`default_nettype wire

// ==== verilog/decode_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
  input  logic               clk,
  input  logic               reset,
  input  cpu_pkg::inst_t     inst,
  input  cpu_pkg::word_t     pc_plus,
  input  logic               stall,
  input  logic               redirect,
  output cpu_pkg::reg_no_t   rs,
  output cpu_pkg::reg_no_t   rt,
  input  cpu_pkg::word_t     rs_val,
  input  cpu_pkg::word_t     rt_val,
  input  cpu_pkg::fwd_sel_t  fwd_sel_rs,
  input  cpu_pkg::fwd_sel_t  fwd_sel_rt,
  input  cpu_pkg::word_t     ex_val,
  input  cpu_pkg::word_t     mem_val,
  input  cpu_pkg::word_t     wb_val,
  output cpu_pkg::op1_t      op1,
  output cpu_pkg::op2_t      op2,
  output cpu_pkg::word_t     a_val,
  output cpu_pkg::word_t     b_val,
  output cpu_pkg::word_t     imm_val,
  output cpu_pkg::word_t     pc_out,
  output cpu_pkg::reg_no_t   wregno,
  output logic               is_br,
  output logic               is_jmp,
  output logic               rd_mem,
  output logic               wr_mem,
  output logic               wr_reg
);
  import cpu_pkg::*;

  logic [5:0] op1_raw;
  op1_t       op1_d;
  reg_no_t    rd;
  logic       is_br_d, is_jmp_d, rd_mem_d, wr_mem_d, wr_reg_d;
  logic       is_br_q, is_jmp_q, rd_mem_q, wr_mem_q, wr_reg_q;

  function automatic word_t pick_operand(fwd_sel_t sel, word_t rf_v, word_t ex_v,
                                         word_t mem_v, word_t wb_v);
    case (sel)
      FWD_FROM_EX:  return ex_v;
      FWD_FROM_MEM: return mem_v;
      FWD_FROM_WB:  return wb_v;
      default:      return rf_v;
    endcase
  endfunction

  // ------------------------------------------------------------------------
  // fields and control
  // ------------------------------------------------------------------------
  assign op1_raw = inst[31:26];
  assign op1_d   = op1_t'(op1_raw);
  assign rd      = inst[11:8];
  assign rs      = inst[7:4];
  assign rt      = inst[3:0];

  assign is_br_d  = (op1_raw[5:2] == 4'b0010);  // BEQ..BNE
  assign is_jmp_d = (op1_d == OP1_JAL);
  assign rd_mem_d = (op1_d == OP1_LW);
  assign wr_mem_d = (op1_d == OP1_SW);
  assign wr_reg_d = (op1_d == OP1_ALUR) || is_jmp_d || rd_mem_d ||
                    (op1_raw[5:3] == 3'b100);  // immediate ALU group

  // ------------------------------------------------------------------------
  // decode latch
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      {is_br_q, is_jmp_q, rd_mem_q, wr_mem_q, wr_reg_q} <= '0;
    end else if (stall || redirect) begin
      {is_br_q, is_jmp_q, rd_mem_q, wr_mem_q, wr_reg_q} <= '0;  // bubble
    end else begin
      {is_br_q, is_jmp_q, rd_mem_q, wr_mem_q, wr_reg_q} <=
        {is_br_d, is_jmp_d, rd_mem_d, wr_mem_d, wr_reg_d};
    end
  end

  always_ff @(posedge clk) begin
    op1     <= op1_d;
    op2     <= op2_t'(inst[25:18]);
    a_val   <= pick_operand(fwd_sel_rs, rs_val, ex_val, mem_val, wb_val);
    b_val   <= pick_operand(fwd_sel_rt, rt_val, ex_val, mem_val, wb_val);
    imm_val <= {{(DBITS-16){inst[23]}}, inst[23:8]};
    pc_out  <= pc_plus;
    wregno  <= (op1_d == OP1_ALUR) ? rd : rt;
  end

  // the instruction now in execute is the first wrong-path one after a redirect
  assign is_br  = is_br_q  & ~redirect;
  assign is_jmp = is_jmp_q & ~redirect;
  assign rd_mem = rd_mem_q & ~redirect;
  assign wr_mem = wr_mem_q & ~redirect;
  assign wr_reg = wr_reg_q & ~redirect;

  // a squashed load in execute must never hold the front end
  no_stall_on_redirect_a: assert property (@(posedge clk) disable iff (reset)
    redirect |-> !stall)
    else $error("load-use stall raised during a redirect");

endmodule

`default_nettype wire

// ==== verilog/execute_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
  input  logic              clk,
  input  logic              reset,
  input  cpu_pkg::op1_t     op1,
  input  cpu_pkg::op2_t     op2,
  input  cpu_pkg::word_t    a_val,
  input  cpu_pkg::word_t    b_val,
  input  cpu_pkg::word_t    imm_val,
  input  cpu_pkg::word_t    pc_in,
  input  cpu_pkg::reg_no_t  wregno,
  input  logic              is_br,
  input  logic              is_jmp,
  input  logic              rd_mem,
  input  logic              wr_mem,
  input  logic              wr_reg,
  output cpu_pkg::word_t    ex_val,
  output logic              redirect,
  output cpu_pkg::word_t    target,
  output cpu_pkg::word_t    alu_out,
  output cpu_pkg::word_t    store_val,
  output cpu_pkg::reg_no_t  wregno_out,
  output logic              rd_mem_out,
  output logic              wr_mem_out,
  output logic              wr_reg_out
);
  import cpu_pkg::*;

  logic signed [DBITS-1:0] a_s;
  logic signed [DBITS-1:0] b_s;
  word_t                   alu_res;
  word_t                   imm_words;
  logic                    br_cond;

  assign a_s       = a_val;
  assign b_s       = b_val;
  assign imm_words = imm_val << 2;

  // ------------------------------------------------------------------------
  // branch condition and ALU, all comparisons signed
  // ------------------------------------------------------------------------
  always_comb begin
    case (op1)
      OP1_BEQ: br_cond = (a_s == b_s);
      OP1_BLT: br_cond = (a_s <  b_s);
      OP1_BLE: br_cond = (a_s <= b_s);
      OP1_BNE: br_cond = (a_s != b_s);
      default: br_cond = 1'b0;
    endcase
  end

  always_comb begin
    case (op1)
      OP1_ALUR: begin
        case (op2)
          OP2_EQ:   alu_res = word_t'(a_s == b_s);
          OP2_LT:   alu_res = word_t'(a_s <  b_s);
          OP2_LE:   alu_res = word_t'(a_s <= b_s);
          OP2_NE:   alu_res = word_t'(a_s != b_s);
          OP2_ADD:  alu_res = a_val + b_val;
          OP2_AND:  alu_res = a_val & b_val;
          OP2_OR:   alu_res = a_val | b_val;
          OP2_XOR:  alu_res = a_val ^ b_val;
          OP2_SUB:  alu_res = a_val - b_val;
          OP2_NAND: alu_res = ~(a_val & b_val);
          OP2_NOR:  alu_res = ~(a_val | b_val);
          OP2_NXOR: alu_res = ~(a_val ^ b_val);
          OP2_RSHF: alu_res = a_s >>> b_val;  // arithmetic
          OP2_LSHF: alu_res = a_val << b_val;
          default:  alu_res = '0;
        endcase
      end
      OP1_LW, OP1_SW, OP1_ADDI: alu_res = a_val + imm_val;  // also address calc
      OP1_ANDI: alu_res = a_val & imm_val;
      OP1_ORI:  alu_res = a_val | imm_val;
      OP1_XORI: alu_res = a_val ^ imm_val;
      OP1_JAL:  alu_res = pc_in;  // link value
      default:  alu_res = '0;
    endcase
  end

  assign ex_val = alu_res;

  // ------------------------------------------------------------------------
  // execute latch
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      redirect   <= 1'b0;
      rd_mem_out <= 1'b0;
      wr_mem_out <= 1'b0;
      wr_reg_out <= 1'b0;
    end else begin
      redirect   <= is_jmp || (is_br && br_cond);
      rd_mem_out <= rd_mem;
      wr_mem_out <= wr_mem;
      wr_reg_out <= wr_reg;
    end
  end

  always_ff @(posedge clk) begin
    target     <= is_jmp ? (a_val + imm_words) : (pc_in + imm_words);
    alu_out    <= alu_res;
    store_val  <= b_val;
    wregno_out <= wregno;
  end

endmodule

`default_nettype wire

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_stage (
  input  logic                clk,
  input  logic                reset,
  input  logic                prog_we,
  input  cpu_pkg::imem_addr_t prog_addr,
  input  cpu_pkg::inst_t      prog_data,
  input  logic                stall,
  input  logic                redirect,
  input  cpu_pkg::word_t      target,
  output cpu_pkg::inst_t      inst,
  output cpu_pkg::word_t      pc_plus
);
  import cpu_pkg::*;

  word_t      pc;
  word_t      pc_seq;
  imem_addr_t fetch_idx;
  inst_t      imem [IMEM_WORDS];

  assign pc_seq    = pc + INST_SIZE;  // predict not-taken
  assign fetch_idx = pc[$bits(imem_addr_t)+1:2];

  // program load port
  always_ff @(posedge clk) begin
    if (prog_we) begin
      imem[prog_addr] <= prog_data;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc   <= START_PC;
      inst <= '0;
    end else if (redirect) begin
      pc   <= target;
      inst <= '0;  // wrong-path fetch becomes a bubble
    end else if (!stall) begin
      pc   <= pc_seq;
      inst <= imem[fetch_idx];
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      pc_plus <= pc_seq;
    end
  end

  // targets come from execute, so alignment depends on the immediate scaling there
  pc_aligned_a: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else $error("fetch pc not word aligned: %h", pc);

endmodule

`default_nettype wire

// ==== verilog/hazard_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module hazard_unit (
  input  cpu_pkg::reg_no_t   rs,
  input  cpu_pkg::reg_no_t   rt,
  input  cpu_pkg::reg_no_t   ex_wregno,
  input  cpu_pkg::reg_no_t   mem_wregno,
  input  cpu_pkg::reg_no_t   wb_regno,
  input  logic               ex_wr_reg,
  input  logic               ex_rd_mem,
  input  logic               mem_wr_reg,
  input  logic               wb_we,
  output cpu_pkg::fwd_sel_t  fwd_sel_rs,
  output cpu_pkg::fwd_sel_t  fwd_sel_rt,
  output logic               stall
);
  import cpu_pkg::*;

  // youngest producer wins
  function automatic fwd_sel_t pick_source(reg_no_t src);
    if (src == '0) begin
      return FWD_REGFILE;  // r0 never forwarded
    end else if (ex_wr_reg && ex_wregno == src) begin
      return FWD_FROM_EX;
    end else if (mem_wr_reg && mem_wregno == src) begin
      return FWD_FROM_MEM;
    end else if (wb_we && wb_regno == src) begin
      return FWD_FROM_WB;
    end
    return FWD_REGFILE;
  endfunction

  always_comb begin
    fwd_sel_rs = pick_source(rs);
    fwd_sel_rt = pick_source(rt);
  end

  // load data only exists at the end of memory, one cycle too late for execute
  assign stall = ex_rd_mem && (ex_wregno != '0) &&
                 ((ex_wregno == rs) || (ex_wregno == rt));

endmodule

`default_nettype wire

// ==== verilog/io_out_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module io_out_reg #(
  parameter type            payload_t = logic [9:0],
  parameter cpu_pkg::word_t base      = '0
) (
  input  logic            clk,
  input  logic            reset,
  input  cpu_pkg::word_t  addr,
  input  cpu_pkg::word_t  wdata,
  input  logic            we,
  output payload_t        value
);

  // store hit keeps only the low bits of the word
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      value <= '0;
    end else if (we && (addr == base)) begin
      value <= payload_t'(wdata[$bits(payload_t)-1:0]);
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mem_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_stage (
  input  logic              clk,
  input  logic              reset,
  input  cpu_pkg::word_t    alu_out,
  input  cpu_pkg::word_t    store_val,
  input  cpu_pkg::reg_no_t  wregno,
  input  logic              rd_mem,
  input  logic              wr_mem,
  input  logic              wr_reg,
  output cpu_pkg::word_t    mem_val,
  output cpu_pkg::word_t    wb_val,
  output cpu_pkg::reg_no_t  wb_regno,
  output logic              wb_we,
  output cpu_pkg::led_t     ledr,
  output cpu_pkg::hex_t     hex
);
  import cpu_pkg::*;

  logic [$clog2(DMEM_WORDS)-1:0] dmem_idx;
  logic                          is_io;
  word_t                         dmem [DMEM_WORDS];

  assign dmem_idx = alu_out[$clog2(DMEM_WORDS)+1:2];
  assign is_io    = (alu_out == ADDR_LEDR) || (alu_out == ADDR_HEX);
  assign mem_val  = rd_mem ? dmem[dmem_idx] : alu_out;  // also the forwarding value

  always_ff @(posedge clk) begin
    if (wr_mem && !is_io) begin
      dmem[dmem_idx] <= store_val;
    end
  end

  // memory latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb_we <= 1'b0;
    end else begin
      wb_we <= wr_reg;
    end
  end

  always_ff @(posedge clk) begin
    wb_val   <= mem_val;
    wb_regno <= wregno;
  end

  // output registers
  io_out_reg #(.payload_t(led_t), .base(ADDR_LEDR)) ledr_reg_i (
    .clk   (clk),
    .reset (reset),
    .addr  (alu_out),
    .wdata (store_val),
    .we    (wr_mem),
    .value (ledr)
  );

  io_out_reg #(.payload_t(hex_t), .base(ADDR_HEX)) hex_reg_i (
    .clk   (clk),
    .reset (reset),
    .addr  (alu_out),
    .wdata (store_val),
    .we    (wr_mem),
    .value (hex)
  );

  // strobes are decoded two stages back and must stay exclusive through the pipe
  rd_wr_exclusive_a: assert property (@(posedge clk) disable iff (reset)
    !(rd_mem && wr_mem))
    else $error("load and store strobes both high in memory stage");

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_file (
  input  logic              clk,
  input  logic              reset,
  input  cpu_pkg::reg_no_t  rs,
  input  cpu_pkg::reg_no_t  rt,
  output cpu_pkg::word_t    rs_val,
  output cpu_pkg::word_t    rt_val,
  input  logic              wb_we,
  input  cpu_pkg::reg_no_t  wb_regno,
  input  cpu_pkg::word_t    wb_val
);
  import cpu_pkg::*;

  word_t regs [2**$bits(reg_no_t)];

  // falling-edge write, so decode sees the value later in the same cycle
  always_ff @(negedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 2**$bits(reg_no_t); i++) begin
        regs[i] <= '0;
      end
    end else if (wb_we) begin
      regs[wb_regno] <= wb_val;
    end
  end

  // r0 is hardwired
  assign rs_val = (rs == '0) ? '0 : regs[rs];
  assign rt_val = (rt == '0) ? '0 : regs[rt];

endmodule

`default_nettype wire
